// File: burst_master.f
+incdir+src
+incdir+tb
src/ahb_pkg.sv
src/burst_addr_gen.sv
src/beat_fifo.sv
src/ahb_issue.sv
src/burst_master.sv
tb/tb_burst_master.sv

// File: run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    -f burst_master.f \
    --top-module tb_burst_master \
    -o tb_burst_master

out=$(./obj_dir/tb_burst_master)
echo "$out"

if echo "$out" | grep -q "Test completed successfully"; then
    exit 0
fi
exit 1

// File: src/ahb_issue.sv
`timescale 1ns/1ps

module ahb_issue import ahb_pkg::*; (
    input  logic      clk,
    input  logic      rstn,
    input  ahb_beat_t head,
    input  logic      empty,
    input  logic      hready,
    output logic      pop,
    output ahb_addr_t haddr,
    output trans_e    htrans,
    output burst_e    hburst,
    output logic      hwrite
);

    ahb_addr_t haddr_nxt;
    trans_e    htrans_nxt;
    burst_e    hburst_nxt;
    logic      hwrite_nxt;

    // take the head on the edge that ends the current address phase
    assign pop = hready && !empty;

    always_comb begin
        haddr_nxt  = haddr;
        htrans_nxt = htrans;
        hburst_nxt = hburst;
        hwrite_nxt = hwrite;
        if (hready) begin
            if (!empty) begin
                haddr_nxt  = head.addr;
                htrans_nxt = head.trans;
                hburst_nxt = head.burst;
                hwrite_nxt = head.write;
            end else begin
                htrans_nxt = IDLE; // nothing queued
            end
        end
        // hready low holds the whole address phase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            haddr  <= '0;
            htrans <= IDLE;
            hburst <= SINGLE;
            hwrite <= 1'b0;
        end else begin
            haddr  <= haddr_nxt;
            htrans <= htrans_nxt;
            hburst <= hburst_nxt;
            hwrite <= hwrite_nxt;
        end
    end

endmodule

// File: src/ahb_pkg.sv
`include "ahb_settings.svh"

package ahb_pkg;

    typedef logic [`AHB_ADDR_W-1:0] ahb_addr_t; // byte address
    typedef logic [1:0] beat_cnt_t;              // beat index in a burst

    // htrans encodings
    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } trans_e;

    // hburst encodings, only the short ones
    typedef enum logic [2:0] {
        SINGLE = 3'b000,
        INCR   = 3'b001,
        WRAP4  = 3'b010,
        INCR4  = 3'b011
    } burst_e;

    typedef struct packed {
        ahb_addr_t addr;
        burst_e    burst;
        logic      write;
    } burst_cmd_t;

    typedef struct packed {
        ahb_addr_t addr;
        trans_e    trans;
        burst_e    burst;
        logic      write;
    } ahb_beat_t;

endpackage

// File: src/ahb_settings.svh
`ifndef AHB_SETTINGS_SVH
`define AHB_SETTINGS_SVH

// bus address width in bits
`define AHB_ADDR_W 32

// wrap window of a 4-beat word burst, in bytes
`define AHB_WRAP_BYTES 16

// beat buffer entries, power of two
`define BEAT_FIFO_DEPTH 4

`endif

// File: src/beat_fifo.sv
`timescale 1ns/1ps
`include "ahb_settings.svh"

module beat_fifo import ahb_pkg::*; (
    input  logic      clk,
    input  logic      rstn,
    input  ahb_beat_t wr_beat,
    input  logic      push,
    input  logic      pop,
    output ahb_beat_t head,
    output logic      full,
    output logic      empty
);

    localparam int DEPTH = `BEAT_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    ahb_beat_t        mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign full  = (count == CNT_W'(DEPTH));
    assign empty = (count == '0);

    // a push into a full fifo only lands when a pop frees the slot
    assign do_pop  = pop && !empty;
    assign do_push = push && (!full || do_pop);

    assign head = mem[rd_ptr];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + PTR_W'(1); // wraps at depth
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + PTR_W'(1);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + CNT_W'(1);
                2'b01:   count <= count - CNT_W'(1);
                default: count <= count;
            endcase
        end
    end

    // storage, no reset
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= wr_beat;
        end
    end

endmodule

// File: src/burst_addr_gen.sv
`timescale 1ns/1ps

module burst_addr_gen import ahb_pkg::*; (
    input  logic       clk,
    input  logic       rstn,
    input  burst_cmd_t cmd,
    input  logic       cmd_strobe,
    input  logic       full,
    output ahb_beat_t  beat,
    output logic       push,
    output logic       cmd_busy
);

    localparam int ADDR_W = $bits(ahb_addr_t);
    localparam int WRAP_W = 4; // 16-byte wrap window

    typedef enum logic {
        GEN_IDLE,
        GEN_RUN
    } gen_state_e;

    gen_state_e        state;
    ahb_addr_t         base;       // start address, window bits cleared
    logic [WRAP_W:0]   offset;     // byte offset of the held beat
    logic [WRAP_W:0]   offset_nxt;
    beat_cnt_t         cnt;
    beat_cnt_t         last_cnt;
    logic              accept;
    logic              advance;

    assign cmd_busy = (state == GEN_RUN);
    assign accept   = (state == GEN_IDLE) && cmd_strobe; // strobe while busy is dropped

    // held beat goes out whenever the fifo has room
    assign push    = (state == GEN_RUN) && !full;
    assign advance = push && (cnt != last_cnt);

    // index of the final beat
    always_comb begin
        case (beat.burst)
            WRAP4,
            INCR4:   last_cnt = 2'd3;
            default: last_cnt = 2'd0; // single, INCR treated as one beat
        endcase
    end

    // next offset, wrapping inside the window for WRAP4
    always_comb begin
        if (beat.burst == WRAP4) begin
            offset_nxt = {1'b0, offset[WRAP_W-1:0] + WRAP_W'(4)};
        end else begin
            offset_nxt = offset + (WRAP_W+1)'(4);
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= GEN_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                GEN_IDLE: begin
                    if (accept) begin
                        state <= GEN_RUN;
                        cnt   <= '0;
                    end
                end
                GEN_RUN: begin
                    if (push) begin
                        if (cnt == last_cnt) begin
                            state <= GEN_IDLE;
                        end else begin
                            cnt <= cnt + 2'd1;
                        end
                    end
                end
                default: state <= GEN_IDLE;
            endcase
        end
    end

    // beat payload, held while full is high
    always_ff @(posedge clk) begin
        if (accept) begin
            base       <= {cmd.addr[ADDR_W-1:WRAP_W], WRAP_W'(0)};
            offset     <= {1'b0, cmd.addr[WRAP_W-1:0]};
            beat.addr  <= cmd.addr;
            beat.trans <= NONSEQ;
            beat.burst <= cmd.burst;
            beat.write <= cmd.write;
        end else if (advance) begin
            offset     <= offset_nxt;
            beat.addr  <= base + ahb_addr_t'(offset_nxt);
            beat.trans <= SEQ;
        end
    end

endmodule

// File: src/burst_master.sv
`timescale 1ns/1ps

module burst_master import ahb_pkg::*; (
    input  logic       clk,
    input  logic       rstn,
    input  burst_cmd_t cmd,
    input  logic       cmd_strobe,
    output logic       cmd_busy,
    input  logic       hready,
    output ahb_addr_t  haddr,
    output trans_e     htrans,
    output burst_e     hburst,
    output logic       hwrite
);

    ahb_beat_t gen_beat; // producer to fifo
    logic      gen_push;
    logic      fifo_full;
    ahb_beat_t fifo_head; // fifo to issuer
    logic      fifo_empty;
    logic      issue_pop;

    burst_addr_gen burst_addr_gen_i (
        .clk        (clk),
        .rstn       (rstn),
        .cmd        (cmd),
        .cmd_strobe (cmd_strobe),
        .full       (fifo_full),
        .beat       (gen_beat),
        .push       (gen_push),
        .cmd_busy   (cmd_busy)
    );

    beat_fifo beat_fifo_i (
        .clk     (clk),
        .rstn    (rstn),
        .wr_beat (gen_beat),
        .push    (gen_push),
        .pop     (issue_pop),
        .head    (fifo_head),
        .full    (fifo_full),
        .empty   (fifo_empty)
    );

    // address phase registers
    ahb_issue ahb_issue_i (
        .clk    (clk),
        .rstn   (rstn),
        .head   (fifo_head),
        .empty  (fifo_empty),
        .hready (hready),
        .pop    (issue_pop),
        .haddr  (haddr),
        .htrans (htrans),
        .hburst (hburst),
        .hwrite (hwrite)
    );

endmodule

// File: tb/tb_burst_table.svh
`ifndef TB_BURST_TABLE_SVH
`define TB_BURST_TABLE_SVH

// one command per row, with the beats the bus must show for it
typedef struct packed {
    ahb_addr_t       addr;
    burst_e          burst;
    logic            write;
    logic [1:0]      hmode;     // 0 always ready, 1 random, 2 long stalls
    logic            drain;     // wait until earlier rows are checked
    logic [2:0]      nbeats;
    ahb_addr_t [0:3] exp_addr;
    logic [0:3][1:0] exp_trans;
} row_t;

localparam int NUM_ROWS = 13;

localparam row_t cmd_table [NUM_ROWS] = '{
    '{32'h0000_0040, SINGLE, 1'b1, 2'd0, 1'b1, 3'd1,
      '{32'h040, 32'h000, 32'h000, 32'h000}, '{NONSEQ, IDLE, IDLE, IDLE}},
    '{32'h0000_1234, SINGLE, 1'b0, 2'd0, 1'b1, 3'd1,
      '{32'h1234, 32'h000, 32'h000, 32'h000}, '{NONSEQ, IDLE, IDLE, IDLE}},
    '{32'h0000_0100, INCR4, 1'b1, 2'd0, 1'b1, 3'd4,
      '{32'h100, 32'h104, 32'h108, 32'h10C}, '{NONSEQ, SEQ, SEQ, SEQ}},
    '{32'h0000_0208, WRAP4, 1'b0, 2'd0, 1'b1, 3'd4,
      '{32'h208, 32'h20C, 32'h200, 32'h204}, '{NONSEQ, SEQ, SEQ, SEQ}},
    '{32'h0000_0200, WRAP4, 1'b1, 2'd0, 1'b1, 3'd4,
      '{32'h200, 32'h204, 32'h208, 32'h20C}, '{NONSEQ, SEQ, SEQ, SEQ}},
    // random wait states
    '{32'h0000_0100, INCR4, 1'b0, 2'd1, 1'b1, 3'd4,
      '{32'h100, 32'h104, 32'h108, 32'h10C}, '{NONSEQ, SEQ, SEQ, SEQ}},
    '{32'h0000_03F4, WRAP4, 1'b1, 2'd1, 1'b1, 3'd4,
      '{32'h3F4, 32'h3F8, 32'h3FC, 32'h3F0}, '{NONSEQ, SEQ, SEQ, SEQ}},
    '{32'h0000_0088, SINGLE, 1'b1, 2'd1, 1'b1, 3'd1,
      '{32'h088, 32'h000, 32'h000, 32'h000}, '{NONSEQ, IDLE, IDLE, IDLE}},
    // back to back under long stalls, fifo fills up
    '{32'h0000_1000, INCR4, 1'b1, 2'd2, 1'b1, 3'd4,
      '{32'h1000, 32'h1004, 32'h1008, 32'h100C}, '{NONSEQ, SEQ, SEQ, SEQ}},
    '{32'h0000_020C, WRAP4, 1'b0, 2'd2, 1'b0, 3'd4,
      '{32'h20C, 32'h200, 32'h204, 32'h208}, '{NONSEQ, SEQ, SEQ, SEQ}},
    '{32'h0000_0500, SINGLE, 1'b0, 2'd2, 1'b0, 3'd1,
      '{32'h500, 32'h000, 32'h000, 32'h000}, '{NONSEQ, IDLE, IDLE, IDLE}},
    '{32'h0000_0FF0, INCR4, 1'b1, 2'd2, 1'b0, 3'd4,
      '{32'hFF0, 32'hFF4, 32'hFF8, 32'hFFC}, '{NONSEQ, SEQ, SEQ, SEQ}},
    '{32'h0000_0804, WRAP4, 1'b1, 2'd2, 1'b0, 3'd4,
      '{32'h804, 32'h808, 32'h80C, 32'h800}, '{NONSEQ, SEQ, SEQ, SEQ}}
};

`endif

// File: tb/tb_burst_master.sv
`timescale 1ns/1ps
`include "ahb_settings.svh"

module tb_burst_master import ahb_pkg::*; ();

    `include "tb_burst_table.svh"

    localparam int WATCHDOG_CYCLES = NUM_ROWS * 4 * 20 + 100;

    logic        clk;
    logic        rstn;
    burst_cmd_t  cmd;
    logic        cmd_strobe;
    logic        cmd_busy;
    logic        hready;
    ahb_addr_t   haddr;
    trans_e      htrans;
    burst_e      hburst;
    logic        hwrite;

    ahb_beat_t   beat_q[$];       // completed address phases, in bus order
    ahb_beat_t   bus_now;
    ahb_beat_t   prev_bus;
    logic        prev_valid = 1'b0;
    logic        prev_hready = 1'b1;
    logic [31:0] lcg_state;
    int          cur_row = 0;     // row under check, also selects the hready mode
    int          next_beat = 0;
    int          pass_cnt = 0;
    int          err_cnt = 0;
    int          hold_pass = 0;
    int          hold_err = 0;

    burst_master burst_master_i (
        .clk        (clk),
        .rstn       (rstn),
        .cmd        (cmd),
        .cmd_strobe (cmd_strobe),
        .cmd_busy   (cmd_busy),
        .hready     (hready),
        .haddr      (haddr),
        .htrans     (htrans),
        .hburst     (hburst),
        .hwrite     (hwrite)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic bit value_ok(input string name, input logic [31:0] exp,
                                    input logic [31:0] act);
        bit ok;
        ok = (act == exp);
        assert (ok) else begin
            $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
        end
        return ok;
    endfunction

    task automatic count(input bit ok);
        if (ok) begin
            pass_cnt++;
        end else begin
            err_cnt++;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        rstn = 1'b0;
        repeat (10) @(posedge clk);
        rstn <= 1'b1;
    end

    // wait states, shaped by the mode of the row being checked
    initial begin
        logic [1:0] mode;
        int         stall_left;
        hready     = 1'b1;
        lcg_state  = 32'd80259;
        stall_left = 0;
        forever begin
            @(posedge clk);
            mode      = (cur_row < NUM_ROWS) ? cmd_table[cur_row].hmode : 2'd0;
            lcg_state = lcg_next(lcg_state);
            if (mode == 2'd1) begin
                hready <= lcg_state[16];
            end else if (mode == 2'd2 && stall_left > 0) begin
                hready <= 1'b0;
                stall_left--;
            end else if (mode == 2'd2 && lcg_state[17:16] == 2'd0) begin
                hready     <= 1'b0;
                stall_left = int'(lcg_state[22:20]) + `BEAT_FIFO_DEPTH;
            end else begin
                hready <= 1'b1;
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout, the bus did not deliver all expected beats in time");
        $display("Test failed");
        $finish;
    end

    // negedge view, hready here decides the coming rising edge
    always @(negedge clk) begin
        if (!rstn) begin
            prev_valid = 1'b0;
        end else begin
            bus_now.addr  = haddr;
            bus_now.trans = htrans;
            bus_now.burst = hburst;
            bus_now.write = hwrite;
            if (prev_valid && !prev_hready) begin // wait state, nothing may move
                if (value_ok("haddr", prev_bus.addr, haddr) &
                    value_ok("htrans", 32'(prev_bus.trans), 32'(htrans)) &
                    value_ok("hburst", 32'(prev_bus.burst), 32'(hburst)) &
                    value_ok("hwrite", 32'(prev_bus.write), 32'(hwrite))) begin
                    hold_pass++;
                end else begin
                    hold_err++;
                end
            end
            if (hready && htrans != IDLE) begin
                beat_q.push_back(bus_now);
            end
            prev_bus    = bus_now;
            prev_hready = hready;
            prev_valid  = 1'b1;
        end
    end

    task automatic drive_commands();
        row_t r;
        for (int i = 0; i < NUM_ROWS; i++) begin
            r = cmd_table[i];
            if (r.drain) begin
                while (cur_row != i) @(negedge clk);
            end
            @(negedge clk);
            while (cmd_busy) @(negedge clk);
            @(posedge clk);
            cmd        <= '{r.addr, r.burst, r.write};
            cmd_strobe <= 1'b1;
            @(posedge clk);
            cmd_strobe <= 1'b0;
        end
    endtask

    task automatic check_beats();
        row_t      r;
        ahb_beat_t got;
        int        errs_before;
        bit        ok;
        for (int i = 0; i < NUM_ROWS; i++) begin
            r           = cmd_table[i];
            errs_before = err_cnt + hold_err;
            for (int b = 0; b < int'(r.nbeats); b++) begin
                while (beat_q.size() <= next_beat) @(negedge clk);
                got = beat_q[next_beat];
                next_beat++;
                ok = value_ok("haddr", r.exp_addr[b], got.addr);
                ok = value_ok("htrans", 32'(r.exp_trans[b]), 32'(got.trans)) && ok;
                ok = value_ok("hburst", 32'(r.burst), 32'(got.burst)) && ok;
                ok = value_ok("hwrite", 32'(r.write), 32'(got.write)) && ok;
                count(ok);
            end
            $display("row %0d burst %0d addr %h beats %0d: %s", i, r.burst, r.addr,
                     r.nbeats, (err_cnt + hold_err == errs_before) ? "pass" : "fail");
            cur_row = i + 1;
        end
    endtask

    initial begin
        bit drained_ok;
        cmd        = '0;
        cmd_strobe = 1'b0;
        @(posedge rstn);
        @(negedge clk);
        count(value_ok("htrans", 32'(IDLE), 32'(htrans)));
        count(value_ok("haddr", 32'h0, haddr));
        count(value_ok("cmd_busy", 32'h0, 32'(cmd_busy)));

        fork
            drive_commands();
            check_beats();
        join

        // anything left over would be a duplicated beat
        repeat (20) @(negedge clk);
        drained_ok = (beat_q.size() == next_beat);
        assert (drained_ok) else begin
            $display("extra beats appeared on the bus after the last command");
        end
        count(drained_ok);

        $display("checks passed %0d, failed %0d", pass_cnt + hold_pass, err_cnt + hold_err);
        if (err_cnt + hold_err == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
